// ==== sources.f ====
+incdir+common
common/axil_regs_pkg.sv
axil_slave/axil_write_ctrl.sv
axil_slave/axil_read_ctrl.sv
src/axil_reg_file.sv
src/axil_regs_top.sv
verif/tb_clk_gen.sv
verif/tb_axil_regs.sv

// ==== Bender.yml ====
package:
  name: axil_regs

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/axil_regs_pkg.sv
      - axil_slave/axil_write_ctrl.sv
      - axil_slave/axil_read_ctrl.sv
      - src/axil_reg_file.sv
      - src/axil_regs_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_axil_regs.sv

// ==== verif/tb_axil_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "axil_regs_defines.svh"

module tb_axil_regs;

	localparam int CLK_PERIOD = 100;
	localparam int N_RAND = 40;
	localparam int MAX_DELAY = 7;
	localparam int STALL = 8;
	// Reset reads, build reads, random writes, readback, read-only pass, back-pressure
	localparam int NUM_TXN = 2 * (`AXIL_NUM_REGS - `AXIL_FIRST_RW_REG)
		+ 3 * `AXIL_FIRST_RW_REG + N_RAND + 6;
	// Handshake cycles plus the longest ready delay and the stall
	localparam int TXN_CYCLES = 8 + MAX_DELAY + STALL;
	localparam int LIMIT_CYCLES = NUM_TXN * TXN_CYCLES + 100;
	localparam logic [63:0] GIT_HASH = 64'h5c1e_94a0_7d3b_e218;
	localparam logic [31:0] TIMESTAMP = 32'h6614_2f80;
	// AXI OKAY response code
	localparam logic [1:0] OKAY = 2'b00;

	logic S_AXI_ACLK;
	logic S_AXI_ARESETN;
	logic [6:0] s_axi_awaddr;
	logic s_axi_awvalid;
	logic s_axi_awready;
	logic [31:0] s_axi_wdata;
	logic [3:0] s_axi_wstrb;
	logic s_axi_wvalid;
	logic s_axi_wready;
	logic [1:0] s_axi_bresp;
	logic s_axi_bvalid;
	logic s_axi_bready;
	logic [6:0] s_axi_araddr;
	logic s_axi_arvalid;
	logic s_axi_arready;
	logic [31:0] s_axi_rdata;
	logic [1:0] s_axi_rresp;
	logic s_axi_rvalid;
	logic s_axi_rready;

	// Reference model of all 32 locations
	logic [31:0] model [0:`AXIL_NUM_REGS-1];
	// Word the next R handshake must carry
	logic [31:0] exp_rdata;
	logic [31:0] rng;
	string test_name;

	tb_clk_gen u_clk_gen (.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN));

	axil_regs_top DUT (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.S_AXI_AWADDR(s_axi_awaddr), .S_AXI_AWVALID(s_axi_awvalid),
		.S_AXI_AWREADY(s_axi_awready), .S_AXI_WDATA(s_axi_wdata),
		.S_AXI_WSTRB(s_axi_wstrb), .S_AXI_WVALID(s_axi_wvalid),
		.S_AXI_WREADY(s_axi_wready), .S_AXI_BRESP(s_axi_bresp),
		.S_AXI_BVALID(s_axi_bvalid), .S_AXI_BREADY(s_axi_bready),
		.S_AXI_ARADDR(s_axi_araddr), .S_AXI_ARVALID(s_axi_arvalid),
		.S_AXI_ARREADY(s_axi_arready), .S_AXI_RDATA(s_axi_rdata),
		.S_AXI_RRESP(s_axi_rresp), .S_AXI_RVALID(s_axi_rvalid),
		.S_AXI_RREADY(s_axi_rready), .git_hash(GIT_HASH), .timestamp(TIMESTAMP)
	);

	// ------------------------------
	// Helpers
	// ------------------------------
	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "Run stopped at first error");
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Byte-lane update, scratch locations only
	task automatic model_write(input logic [6:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		if (addr[6:2] >= `AXIL_FIRST_RW_REG)
		begin
			for (int b = 0; b < 4; b++)
			begin
				if (strb[b])
					model[addr[6:2]][8*b +: 8] = data[8*b +: 8];
			end
		end
	endtask

	// One write, B held off for bdelay cycles
	task automatic write_word(input logic [6:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input int bdelay);
		@(posedge S_AXI_ACLK);
		s_axi_awaddr <= addr;
		s_axi_wdata <= data;
		s_axi_wstrb <= strb;
		s_axi_awvalid <= 1'b1;
		s_axi_wvalid <= 1'b1;
		// Ready seen mid-cycle, handshake on the next edge
		do @(negedge S_AXI_ACLK); while (!s_axi_awready);
		@(posedge S_AXI_ACLK);
		s_axi_awvalid <= 1'b0;
		s_axi_wvalid <= 1'b0;
		model_write(addr, data, strb);
		repeat (bdelay) @(posedge S_AXI_ACLK);
		s_axi_bready <= 1'b1;
		do @(negedge S_AXI_ACLK); while (!s_axi_bvalid);
		@(posedge S_AXI_ACLK);
		s_axi_bready <= 1'b0;
	endtask

	// One read, R held off for rdelay cycles
	task automatic read_check(input logic [6:0] addr, input int rdelay);
		@(posedge S_AXI_ACLK);
		s_axi_araddr <= addr;
		s_axi_arvalid <= 1'b1;
		exp_rdata <= model[addr[6:2]];
		do @(negedge S_AXI_ACLK); while (!s_axi_arready);
		@(posedge S_AXI_ACLK);
		s_axi_arvalid <= 1'b0;
		repeat (rdelay) @(posedge S_AXI_ACLK);
		s_axi_rready <= 1'b1;
		do @(negedge S_AXI_ACLK); while (!s_axi_rvalid);
		@(posedge S_AXI_ACLK);
		s_axi_rready <= 1'b0;
	endtask

	// Second write presented while the first B is stalled
	task automatic stalled_write_pair(input logic [6:0] addr_a, input logic [31:0] data_a,
		input logic [6:0] addr_b, input logic [31:0] data_b);
		@(posedge S_AXI_ACLK);
		s_axi_awaddr <= addr_a;
		s_axi_wdata <= data_a;
		s_axi_wstrb <= 4'b1111;
		s_axi_awvalid <= 1'b1;
		s_axi_wvalid <= 1'b1;
		do @(negedge S_AXI_ACLK); while (!s_axi_awready);
		@(posedge S_AXI_ACLK);
		s_axi_awaddr <= addr_b;
		s_axi_wdata <= data_b;
		s_axi_wstrb <= 4'b1001;
		model_write(addr_a, data_a, 4'b1111);
		repeat (STALL) @(posedge S_AXI_ACLK);
		// BREADY stays high across both responses
		s_axi_bready <= 1'b1;
		do @(negedge S_AXI_ACLK); while (!s_axi_awready);
		@(posedge S_AXI_ACLK);
		s_axi_awvalid <= 1'b0;
		s_axi_wvalid <= 1'b0;
		model_write(addr_b, data_b, 4'b1001);
		do @(negedge S_AXI_ACLK); while (!s_axi_bvalid);
		@(posedge S_AXI_ACLK);
		s_axi_bready <= 1'b0;
	endtask

	// Second address presented while the first R is stalled
	task automatic stalled_read_pair(input logic [6:0] addr_a, input logic [6:0] addr_b);
		@(posedge S_AXI_ACLK);
		s_axi_araddr <= addr_a;
		s_axi_arvalid <= 1'b1;
		exp_rdata <= model[addr_a[6:2]];
		do @(negedge S_AXI_ACLK); while (!s_axi_arready);
		@(posedge S_AXI_ACLK);
		s_axi_araddr <= addr_b;
		repeat (STALL) @(posedge S_AXI_ACLK);
		s_axi_rready <= 1'b1;
		do @(negedge S_AXI_ACLK); while (!s_axi_rvalid);
		// First response taken here, expectation moves on after the sample
		@(posedge S_AXI_ACLK);
		exp_rdata <= model[addr_b[6:2]];
		do @(negedge S_AXI_ACLK); while (!s_axi_arready);
		@(posedge S_AXI_ACLK);
		s_axi_arvalid <= 1'b0;
		do @(negedge S_AXI_ACLK); while (!s_axi_rvalid);
		@(posedge S_AXI_ACLK);
		s_axi_rready <= 1'b0;
	endtask

	// ------------------------------
	// Checks
	// ------------------------------
	chk_reset_idle: assert property (@(posedge S_AXI_ACLK) $rose(S_AXI_ARESETN) |->
		!(s_axi_awready || s_axi_wready || s_axi_bvalid || s_axi_arready || s_axi_rvalid))
		else stop_with_failure("Handshake outputs were not idle when reset was released");

	chk_rdata: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_rvalid && s_axi_rready |-> s_axi_rdata == exp_rdata)
		else stop_with_failure($sformatf("Mismatch %s RDATA: expected %h, actual %h",
			test_name, $sampled(exp_rdata), $sampled(s_axi_rdata)));

	chk_rresp: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_rvalid |-> s_axi_rresp == OKAY)
		else stop_with_failure($sformatf("Mismatch %s RRESP: expected %h, actual %h",
			test_name, OKAY, $sampled(s_axi_rresp)));

	chk_bresp: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_bvalid |-> s_axi_bresp == OKAY)
		else stop_with_failure($sformatf("Mismatch %s BRESP: expected %h, actual %h",
			test_name, OKAY, $sampled(s_axi_bresp)));

	// Address and data are taken in the same cycle
	chk_ready_pair: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_awready == s_axi_wready)
		else stop_with_failure("AWREADY and WREADY were not raised together");

	chk_b_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
		else stop_with_failure("BVALID dropped while BREADY was withheld");

	chk_aw_blocked: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_bvalid |-> !s_axi_awready)
		else stop_with_failure("A new write was accepted while a write response was pending");

	chk_r_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
		else stop_with_failure("Read response changed while RREADY was withheld");

	chk_ar_blocked: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_rvalid |-> !s_axi_arready)
		else stop_with_failure("A read address was accepted while a read response was pending");

	// ------------------------------
	// Stimulus
	// ------------------------------
	initial
	begin
		logic [31:0] sel;
		logic [31:0] data;
		logic [4:0] idx;
		s_axi_awaddr = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata = '0;
		s_axi_wstrb = '0;
		s_axi_wvalid = 1'b0;
		s_axi_bready = 1'b0;
		s_axi_araddr = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready = 1'b0;
		exp_rdata = '0;
		rng = 32'd35;
		// Build words from the fixed inputs, scratch area cleared
		for (int i = 0; i < `AXIL_NUM_REGS; i++)
			model[i] = '0;
		model[0] = GIT_HASH[31:0];
		model[1] = GIT_HASH[63:32];
		model[2] = TIMESTAMP;
		model[3] = `AXIL_SIG_WORD_A;
		model[4] = `AXIL_SIG_WORD_B;
		model[5] = TIMESTAMP;
		wait (S_AXI_ARESETN);

		test_name = "reset_state";
		for (int i = `AXIL_FIRST_RW_REG; i < `AXIL_NUM_REGS; i++)
			read_check({5'(i), 2'b00}, 0);

		test_name = "build_words";
		for (int i = 0; i < `AXIL_FIRST_RW_REG; i++)
			read_check({5'(i), 2'b00}, 1);

		test_name = "scratch_rw";
		for (int n = 0; n < N_RAND; n++)
		begin
			sel = xorshift32(rng);
			data = xorshift32(sel);
			rng = data;
			idx = 5'(`AXIL_FIRST_RW_REG + sel % (`AXIL_NUM_REGS - `AXIL_FIRST_RW_REG));
			// Low address bits are a byte offset and must not matter
			write_word({idx, sel[1:0]}, data, sel[11:8], int'(sel[14:12]));
		end
		for (int i = `AXIL_FIRST_RW_REG; i < `AXIL_NUM_REGS; i++)
		begin
			rng = xorshift32(rng);
			read_check({5'(i), rng[1:0]}, int'(rng[6:4]));
		end

		test_name = "read_only";
		for (int i = 0; i < `AXIL_FIRST_RW_REG; i++)
		begin
			rng = xorshift32(rng);
			write_word({5'(i), 2'b00}, rng, 4'hf, 0);
		end
		for (int i = 0; i < `AXIL_FIRST_RW_REG; i++)
			read_check({5'(i), 2'b00}, 0);

		test_name = "back_pressure";
		rng = xorshift32(rng);
		fork
			stalled_write_pair({5'd20, 2'b00}, rng, {5'd21, 2'b00}, ~rng);
			stalled_read_pair({5'd3, 2'b00}, {5'd9, 2'b00});
		join
		read_check({5'd20, 2'b00}, 0);
		read_check({5'd21, 2'b00}, 0);

		$display("RESULT: PASS");
		$finish;
	end

	// Run limit from the transaction count and the worst case per transaction
	initial
	begin
		#(LIMIT_CYCLES * CLK_PERIOD);
		stop_with_failure($sformatf("Timeout after %0d cycles, a handshake never completed",
			LIMIT_CYCLES));
	end

endmodule

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen
(
	output logic S_AXI_ACLK,
	output logic S_AXI_ARESETN
);

	// Half of the 100 ns period
	localparam int HALF_PERIOD = 50;

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #HALF_PERIOD S_AXI_ACLK = ~S_AXI_ACLK;
	end

	// Reset low through the first 5 rising edges, released on an edge
	initial
	begin
		S_AXI_ARESETN = 1'b0;
		repeat (5) @(posedge S_AXI_ACLK);
		S_AXI_ARESETN <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== src/axil_regs_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "axil_regs_defines.svh"

module axil_regs_top
(
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	// Write address
	input wire axil_regs_pkg::axil_addr_u S_AXI_AWADDR,
	input wire S_AXI_AWVALID,
	output logic S_AXI_AWREADY,
	// Write data
	input wire axil_regs_pkg::axil_data_t S_AXI_WDATA,
	input wire axil_regs_pkg::axil_strb_t S_AXI_WSTRB,
	input wire S_AXI_WVALID,
	output logic S_AXI_WREADY,
	// Write response
	output axil_regs_pkg::axil_resp_t S_AXI_BRESP,
	output logic S_AXI_BVALID,
	input wire S_AXI_BREADY,
	// Read address
	input wire axil_regs_pkg::axil_addr_u S_AXI_ARADDR,
	input wire S_AXI_ARVALID,
	output logic S_AXI_ARREADY,
	// Read data
	output axil_regs_pkg::axil_data_t S_AXI_RDATA,
	output axil_regs_pkg::axil_resp_t S_AXI_RRESP,
	output logic S_AXI_RVALID,
	input wire S_AXI_RREADY,
	// Static build information
	input wire [2*`AXIL_DATA_W-1:0] git_hash,
	input wire axil_regs_pkg::axil_data_t timestamp
);

	import axil_regs_pkg::*;

	// ------------------------------
	// Internal register-file links
	// ------------------------------
	logic wr_en;
	axil_reg_idx_t wr_idx;
	axil_data_t wr_data;
	axil_strb_t wr_strb;
	axil_reg_idx_t rd_idx;
	axil_data_t rd_data;

	// AW, W and B channels
	axil_write_ctrl u_write_ctrl (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.s_axi_awaddr(S_AXI_AWADDR), .s_axi_awvalid(S_AXI_AWVALID),
		.s_axi_awready(S_AXI_AWREADY), .s_axi_wdata(S_AXI_WDATA),
		.s_axi_wstrb(S_AXI_WSTRB), .s_axi_wvalid(S_AXI_WVALID),
		.s_axi_wready(S_AXI_WREADY), .s_axi_bresp(S_AXI_BRESP),
		.s_axi_bvalid(S_AXI_BVALID), .s_axi_bready(S_AXI_BREADY),
		.wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data), .wr_strb(wr_strb)
	);

	// AR and R channels, independent of the write side
	axil_read_ctrl u_read_ctrl (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.s_axi_araddr(S_AXI_ARADDR), .s_axi_arvalid(S_AXI_ARVALID),
		.s_axi_arready(S_AXI_ARREADY), .s_axi_rdata(S_AXI_RDATA),
		.s_axi_rresp(S_AXI_RRESP), .s_axi_rvalid(S_AXI_RVALID),
		.s_axi_rready(S_AXI_RREADY), .rd_idx(rd_idx), .rd_data(rd_data)
	);

	// Scratch storage and build-word lookup
	axil_reg_file u_reg_file (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data), .wr_strb(wr_strb),
		.rd_idx(rd_idx), .rd_data(rd_data),
		.git_hash(git_hash), .timestamp(timestamp)
	);

endmodule

`default_nettype wire

// ==== src/axil_reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "axil_regs_defines.svh"

module axil_reg_file
(
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	input wire wr_en,
	input wire axil_regs_pkg::axil_reg_idx_t wr_idx,
	input wire axil_regs_pkg::axil_data_t wr_data,
	input wire axil_regs_pkg::axil_strb_t wr_strb,
	input wire axil_regs_pkg::axil_reg_idx_t rd_idx,
	output axil_regs_pkg::axil_data_t rd_data,
	input wire [2*`AXIL_DATA_W-1:0] git_hash,
	input wire axil_regs_pkg::axil_data_t timestamp
);

	import axil_regs_pkg::*;

	// Scratch storage, indexed by word location
	axil_data_t scratch_q [`AXIL_FIRST_RW_REG:`AXIL_NUM_REGS-1];
	logic wr_hit;

	// ------------------------------
	// Scratch registers
	// ------------------------------
	// Writes below the first writable index are dropped here
	assign wr_hit = wr_en && (wr_idx >= `AXIL_FIRST_RW_REG);

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			for (int i = `AXIL_FIRST_RW_REG; i < `AXIL_NUM_REGS; i++)
				scratch_q[i] <= '0;
		end
		else if (wr_hit)
		begin
			// Only strobed lanes change
			for (int b = 0; b < `AXIL_STRB_W; b++)
			begin
				if (wr_strb[b])
					scratch_q[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
			end
		end
	end

	// ------------------------------
	// Read multiplexer
	// ------------------------------
	always_comb
	begin
		case (rd_idx)
			// Source revision hash, low word first
			0:
				rd_data = git_hash[`AXIL_DATA_W-1:0];
			1:
				rd_data = git_hash[2*`AXIL_DATA_W-1:`AXIL_DATA_W];
			2:
				rd_data = timestamp;
			// Fixed signatures let software find the block
			3:
				rd_data = `AXIL_SIG_WORD_A;
			4:
				rd_data = `AXIL_SIG_WORD_B;
			// Timestamp mirrored at 0x14
			5:
				rd_data = timestamp;
			default:
				rd_data = scratch_q[rd_idx];
		endcase
	end

	// Write index must be clean whenever the strobe fires
	a_wr_idx_known: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		wr_en |-> !$isunknown(wr_idx))
		else $error("Unknown register index on write strobe");

endmodule

`default_nettype wire

// ==== axil_slave/axil_read_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "axil_regs_defines.svh"

module axil_read_ctrl
(
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	input wire axil_regs_pkg::axil_addr_u s_axi_araddr,
	input wire s_axi_arvalid,
	output logic s_axi_arready,
	output axil_regs_pkg::axil_data_t s_axi_rdata,
	output axil_regs_pkg::axil_resp_t s_axi_rresp,
	output logic s_axi_rvalid,
	input wire s_axi_rready,
	output axil_regs_pkg::axil_reg_idx_t rd_idx,
	input wire axil_regs_pkg::axil_data_t rd_data
);

	import axil_regs_pkg::*;

	logic arready_q;
	logic rvalid_q;
	axil_data_t rdata_q;
	axil_addr_u ar_addr_q;
	logic rd_accept;
	logic rd_fire;

	// ------------------------------
	// Address channel
	// ------------------------------
	// Held off while a response waits, so no address gets dropped
	assign rd_accept = s_axi_arvalid && !arready_q && !rvalid_q;
	assign rd_fire = arready_q && s_axi_arvalid && !rvalid_q;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			arready_q <= 1'b0;
		else
			arready_q <= rd_accept;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (rd_accept)
			ar_addr_q.raw <= s_axi_araddr.raw;
	end

	// Lookup index into the register file
	assign rd_idx = ar_addr_q.fields.idx;

	// ------------------------------
	// Data channel
	// ------------------------------
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			rvalid_q <= 1'b0;
			rdata_q <= '0;
		end
		else if (rd_fire)
		begin
			// Looked-up word captured in the ARREADY cycle
			rvalid_q <= 1'b1;
			rdata_q <= rd_data;
		end
		else if (rvalid_q && s_axi_rready)
			rvalid_q <= 1'b0;
	end

	assign s_axi_arready = arready_q;
	assign s_axi_rvalid = rvalid_q;
	assign s_axi_rdata = rdata_q;
	assign s_axi_rresp = `AXIL_RESP_OKAY;

	// Data must not move under a stalled response
	a_rdata_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		rvalid_q && !s_axi_rready |=> $stable(rdata_q))
		else $error("RDATA changed while RVALID held without RREADY");

endmodule

`default_nettype wire

// ==== axil_slave/axil_write_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "axil_regs_defines.svh"

module axil_write_ctrl
(
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	input wire axil_regs_pkg::axil_addr_u s_axi_awaddr,
	input wire s_axi_awvalid,
	output logic s_axi_awready,
	input wire axil_regs_pkg::axil_data_t s_axi_wdata,
	input wire axil_regs_pkg::axil_strb_t s_axi_wstrb,
	input wire s_axi_wvalid,
	output logic s_axi_wready,
	output axil_regs_pkg::axil_resp_t s_axi_bresp,
	output logic s_axi_bvalid,
	input wire s_axi_bready,
	output logic wr_en,
	output axil_regs_pkg::axil_reg_idx_t wr_idx,
	output axil_regs_pkg::axil_data_t wr_data,
	output axil_regs_pkg::axil_strb_t wr_strb
);

	import axil_regs_pkg::*;

	// Low from acceptance until the B handshake
	logic aw_en;
	// Shared AWREADY/WREADY pulse
	logic aw_w_ready_q;
	logic bvalid_q;
	axil_addr_u aw_addr_q;
	logic wr_accept;
	logic wr_fire;

	// ------------------------------
	// Acceptance
	// ------------------------------
	// Address and data must both be present, one write at a time
	assign wr_accept = s_axi_awvalid && s_axi_wvalid && !aw_w_ready_q && aw_en;
	// Both handshakes complete in the ready cycle
	assign wr_fire = aw_w_ready_q && s_axi_awvalid && s_axi_wvalid;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			aw_w_ready_q <= 1'b0;
			aw_en <= 1'b1;
		end
		else if (wr_accept)
		begin
			aw_w_ready_q <= 1'b1;
			aw_en <= 1'b0;
		end
		else
		begin
			aw_w_ready_q <= 1'b0;
			// Reopen only once the response is taken
			if (bvalid_q && s_axi_bready)
				aw_en <= 1'b1;
		end
	end

	// Address captured on acceptance, used in the ready cycle
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (wr_accept)
			aw_addr_q.raw <= s_axi_awaddr.raw;
	end

	// ------------------------------
	// Register-write command
	// ------------------------------
	assign wr_en = wr_fire;
	assign wr_idx = aw_addr_q.fields.idx;
	// Master holds WDATA/WSTRB until WREADY so they are still valid here
	assign wr_data = s_axi_wdata;
	assign wr_strb = s_axi_wstrb;

	// ------------------------------
	// Write response
	// ------------------------------
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			bvalid_q <= 1'b0;
		else if (wr_fire && !bvalid_q)
			bvalid_q <= 1'b1;
		else if (bvalid_q && s_axi_bready)
			bvalid_q <= 1'b0;
	end

	assign s_axi_awready = aw_w_ready_q;
	assign s_axi_wready = aw_w_ready_q;
	assign s_axi_bvalid = bvalid_q;
	// No error cases, every write is OKAY
	assign s_axi_bresp = `AXIL_RESP_OKAY;

	// Response may not be withdrawn before the master takes it
	a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		bvalid_q && !s_axi_bready |=> bvalid_q)
		else $error("BVALID dropped before BREADY");

	// A new register write never overlaps a pending response
	a_no_wr_during_b: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		wr_en |-> !bvalid_q)
		else $error("Register write while BVALID pending");

endmodule

`default_nettype wire

// ==== common/axil_regs_pkg.sv ====
`default_nettype none

`include "axil_regs_defines.svh"

package axil_regs_pkg;

	// One bus word and its byte-lane enables
	typedef logic [`AXIL_DATA_W-1:0] axil_data_t;
	typedef logic [`AXIL_STRB_W-1:0] axil_strb_t;

	// Word index into the 32-entry map
	typedef logic [`AXIL_REG_IDX_W-1:0] axil_reg_idx_t;

	// BRESP / RRESP code
	typedef logic [1:0] axil_resp_t;

	// Byte address split into word index and byte offset
	typedef struct packed {
		axil_reg_idx_t idx;
		logic [`AXIL_BYTE_OFS_W-1:0] ofs;
	} axil_addr_fields_t;

	// Same 7 bits, seen raw or as index plus offset
	typedef union packed {
		logic [`AXIL_ADDR_W-1:0] raw;
		axil_addr_fields_t fields;
	} axil_addr_u;

endpackage

`default_nettype wire

// ==== common/axil_regs_defines.svh ====
`ifndef AXIL_REGS_DEFINES_SVH
`define AXIL_REGS_DEFINES_SVH

// ------------------------------
// Bus widths
// ------------------------------
`define AXIL_DATA_W 32
`define AXIL_ADDR_W 7
`define AXIL_STRB_W 4
// Word index and byte offset split the byte address
`define AXIL_REG_IDX_W 5
`define AXIL_BYTE_OFS_W 2

// ------------------------------
// Register map
// ------------------------------
`define AXIL_NUM_REGS 32
// Locations below this index hold build information only
`define AXIL_FIRST_RW_REG 6
`define AXIL_SIG_WORD_A 32'hbaaf_deec
`define AXIL_SIG_WORD_B 32'hdead_0666
`define AXIL_RESP_OKAY 2'b00

`endif
